// File: texBuffer_consts.svh
`ifndef TEX_BUFFER_CONSTS_SVH
`define TEX_BUFFER_CONSTS_SVH

// Texel format, RGBA4444
`define TEX_PIXEL_WIDTH 16

// Write stream carries two texels per beat
`define TEX_STREAM_WIDTH 32

// Log2 of the largest texture edge (64 texels)
`define TEX_MAX_LOG2 6

// One bank holds half of 64x64 texels
`define TEX_BANK_ADDR_WIDTH 11

// Coordinates are Q1.15
`define TEX_COORD_FRAC 15

`endif

// File: texelPkg.sv
`include "texBuffer_consts.svh"

package texelPkg;

    // Log2 of the texel count on one axis
    typedef enum logic [2:0]
    {
        SIZE_1  = 3'd0,
        SIZE_2  = 3'd1,
        SIZE_4  = 3'd2,
        SIZE_8  = 3'd3,
        SIZE_16 = 3'd4,
        SIZE_32 = 3'd5,
        SIZE_64 = 3'd6
    } texSize_e;

    typedef logic [`TEX_PIXEL_WIDTH - 1 : 0] pixel_t;

    typedef logic [`TEX_COORD_FRAC : 0] texCoord_t;     // Q1.15

    typedef logic [`TEX_COORD_FRAC : 0] subCoord_t;     // Q0.16

    typedef logic [`TEX_BANK_ADDR_WIDTH - 1 : 0] bankAddr_t;

    // Element 0 is the even texel, element 1 the odd one
    typedef logic [`TEX_STREAM_WIDTH / `TEX_PIXEL_WIDTH - 1 : 0][`TEX_PIXEL_WIDTH - 1 : 0]
        streamWord_t;

endpackage

// File: texelIfs.sv
`timescale 1ns/10ps

// Texture size and clamp settings, static between cfgWrite pulses
interface texConfigIf import texelPkg::*; ();
    texSize_e sizeS;
    texSize_e sizeT;
    logic     clampS;
    logic     clampT;

    modport source (output sizeS, output sizeT, output clampS, output clampT);
    modport sink   (input sizeS, input sizeT, input clampS, input clampT);
endinterface

// Shared write port of both banks
interface bankWriteIf import texelPkg::*; ();
    logic      wrEn;
    bankAddr_t wrAddr;
    pixel_t    dataEven;
    pixel_t    dataOdd;

    modport source (output wrEn, output wrAddr, output dataEven, output dataOdd);
    modport sink   (input wrEn, input wrAddr, input dataEven, input dataOdd);
endinterface

// Registered decode info, aligned with the bank read data
interface quadDecodeIf ();
    logic sel00;    // Bank bit of each quad texel
    logic sel01;
    logic sel10;
    logic sel11;
    logic clampS;
    logic clampT;

    modport source (output sel00, output sel01, output sel10, output sel11,
                    output clampS, output clampT);
    modport sink   (input sel00, input sel01, input sel10, input sel11,
                    input clampS, input clampT);
endinterface

// File: texConfigRegs.sv
`timescale 1ns/10ps

module texConfigRegs import texelPkg::*;
(
    input  logic              aclk,
    input  logic              resetn,

    input  logic              cfgWrite,
    input  texSize_e          cfgSizeS,
    input  texSize_e          cfgSizeT,
    input  logic              cfgClampS,
    input  logic              cfgClampT,

    texConfigIf.source        cfg
);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            cfg.sizeS  <= SIZE_1;   // Single texel, no wrap handling needed
            cfg.sizeT  <= SIZE_1;
            cfg.clampS <= 1'b0;
            cfg.clampT <= 1'b0;
        end
        else if (cfgWrite)
        begin
            cfg.sizeS  <= cfgSizeS;
            cfg.sizeT  <= cfgSizeT;
            cfg.clampS <= cfgClampS;
            cfg.clampT <= cfgClampT;
        end
    end

    // Codes 7 would address past the 64x64 texture
    assertSizeRange : assert property (
        @(posedge aclk) disable iff (!resetn)
        cfgWrite |=> (cfg.sizeS <= SIZE_64) && (cfg.sizeT <= SIZE_64)
    )
    else
    begin
        $error("texConfigRegs: size code out of range");
    end

endmodule

// File: texelAddrGen.sv
`timescale 1ns/10ps
`include "texBuffer_consts.svh"

module texelAddrGen import texelPkg::*;
(
    input  logic              aclk,
    input  logic              resetn,

    input  texCoord_t         texelS,
    input  texCoord_t         texelT,
    texConfigIf.sink          cfg,

    output bankAddr_t         rdAddrEven0,    // Row 0, read-only ports
    output bankAddr_t         rdAddrOdd0,
    output bankAddr_t         rdAddrEven1,    // Row 1, shared ports
    output bankAddr_t         rdAddrOdd1,

    quadDecodeIf.source       dec,
    output subCoord_t         subCoordS,
    output subCoord_t         subCoordT
);

    localparam int idxWidth = `TEX_MAX_LOG2;
    localparam int linWidth = 2 * idxWidth;

    logic [idxWidth - 1 : 0] idxS0;
    logic [idxWidth - 1 : 0] idxS1;
    logic [idxWidth - 1 : 0] idxT0;
    logic [idxWidth - 1 : 0] idxT1;
    subCoord_t               fracS;
    subCoord_t               fracT;
    logic                    wrapS;
    logic                    wrapT;

    logic [linWidth - 1 : 0] addr00;
    logic [linWidth - 1 : 0] addr01;
    logic [linWidth - 1 : 0] addr10;
    logic [linWidth - 1 : 0] addr11;

    // Texel indices, fraction and wrap flag of one axis
    function automatic void axisDecode(
        input  texCoord_t               coord,
        input  texSize_e                size,
        output logic [idxWidth - 1 : 0] idx0,
        output logic [idxWidth - 1 : 0] idx1,
        output subCoord_t               frac,
        output logic                    wrap
    );
        int unsigned             shamt;
        texCoord_t               coord1;
        logic [idxWidth - 1 : 0] mask;

        shamt = `TEX_COORD_FRAC - int'(size);
        mask  = (idxWidth'(1) << size) - idxWidth'(1);  // Wraps to all ones at 64

        if (size == SIZE_1)
        begin
            coord1 = coord;
            frac   = '0;
        end
        else
        begin
            coord1 = coord + (16'd1 << shamt);
            frac   = (coord & ((16'd1 << shamt) - 16'd1)) << (int'(size) + 1);
        end

        idx0 = idxWidth'(coord >> shamt) & mask;
        idx1 = idxWidth'(coord1 >> shamt) & mask;
        wrap = (coord > coord1) || (!coord[15] && coord1[15]);
    endfunction

    // Row stride equals the S size, so T sits right above the S bits
    function automatic logic [linWidth - 1 : 0] linearAddr(
        input logic [idxWidth - 1 : 0] idxT,
        input logic [idxWidth - 1 : 0] idxS,
        input texSize_e                sizeS
    );
        linearAddr = ({{idxWidth{1'b0}}, idxT} << sizeS) | {{idxWidth{1'b0}}, idxS};
    endfunction

    always_comb
    begin
        axisDecode(texelS, cfg.sizeS, idxS0, idxS1, fracS, wrapS);
        axisDecode(texelT, cfg.sizeT, idxT0, idxT1, fracT, wrapT);

        addr00 = linearAddr(idxT0, idxS0, cfg.sizeS);
        addr01 = linearAddr(idxT0, idxS1, cfg.sizeS);
        addr10 = linearAddr(idxT1, idxS0, cfg.sizeS);
        addr11 = linearAddr(idxT1, idxS1, cfg.sizeS);
    end

    // Odd texel (0,0) puts its right neighbour into the even bank
    assign rdAddrEven0 = addr00[0] ? addr01[linWidth - 1 : 1] : addr00[linWidth - 1 : 1];
    assign rdAddrOdd0  = addr00[0] ? addr00[linWidth - 1 : 1] : addr01[linWidth - 1 : 1];
    assign rdAddrEven1 = addr10[0] ? addr11[linWidth - 1 : 1] : addr10[linWidth - 1 : 1];
    assign rdAddrOdd1  = addr10[0] ? addr10[linWidth - 1 : 1] : addr11[linWidth - 1 : 1];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            dec.sel00  <= 1'b0;
            dec.sel01  <= 1'b0;
            dec.sel10  <= 1'b0;
            dec.sel11  <= 1'b0;
            dec.clampS <= 1'b0;
            dec.clampT <= 1'b0;
            subCoordS  <= '0;
            subCoordT  <= '0;
        end
        else
        begin
            dec.sel00  <= addr00[0];
            dec.sel01  <= addr01[0];
            dec.sel10  <= addr10[0];
            dec.sel11  <= addr11[0];
            dec.clampS <= cfg.clampS && wrapS;
            dec.clampT <= cfg.clampT && wrapT;
            subCoordS  <= fracS;
            subCoordT  <= fracT;
        end
    end

endmodule

// File: texelWriteCtrl.sv
`timescale 1ns/10ps

module texelWriteCtrl import texelPkg::*;
(
    input  logic              aclk,
    input  logic              resetn,

    input  logic              streamValid,
    input  logic              streamLast,
    input  streamWord_t       streamData,

    bankWriteIf.source        wr
);

    bankAddr_t writeAddr;

    // Linear texel order, one bank word per beat
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            writeAddr <= '0;
        end
        else if (streamValid)
        begin
            if (streamLast)
            begin
                writeAddr <= '0;    // Next texture starts over
            end
            else
            begin
                writeAddr <= writeAddr + 1'b1;
            end
        end
    end

    assign wr.wrEn     = streamValid;
    assign wr.wrAddr   = writeAddr;
    assign wr.dataEven = streamData[0];   // Low half
    assign wr.dataOdd  = streamData[1];

    assertLastWithValid : assert property (
        @(posedge aclk) disable iff (!resetn)
        streamLast |-> streamValid
    )
    else
    begin
        $error("texelWriteCtrl: streamLast without streamValid");
    end

endmodule

// File: texelBank.sv
`timescale 1ns/10ps
`include "texBuffer_consts.svh"

module texelBank import texelPkg::*;
#(
    parameter bit useOdd = 1'b0     // Stores the high stream half when set
)
(
    input  logic              aclk,

    bankWriteIf.sink          wr,

    input  bankAddr_t         rdAddrA,
    input  bankAddr_t         rdAddrB,
    output pixel_t            rdDataA,
    output pixel_t            rdDataB
);

    localparam int depth = 1 << `TEX_BANK_ADDR_WIDTH;

    pixel_t mem [depth];
    pixel_t wrData;

    assign wrData = useOdd ? wr.dataOdd : wr.dataEven;

    // Port A is shared, a write blocks the read
    always_ff @(posedge aclk)
    begin
        if (wr.wrEn)
        begin
            mem[wr.wrAddr] <= wrData;
        end
        else
        begin
            rdDataA <= mem[rdAddrA];
        end
    end

    // Port B only reads
    always_ff @(posedge aclk)
    begin
        rdDataB <= mem[rdAddrB];
    end

endmodule

// File: texelQuadSelect.sv
`timescale 1ns/10ps

module texelQuadSelect import texelPkg::*;
(
    quadDecodeIf.sink         dec,

    input  pixel_t            rdEven0,
    input  pixel_t            rdOdd0,
    input  pixel_t            rdEven1,
    input  pixel_t            rdOdd1,

    output pixel_t            texel00,    // (0,0)
    output pixel_t            texel01,    // (1,0), next in S
    output pixel_t            texel10,    // (0,1), next in T
    output pixel_t            texel11     // (1,1)
);

    pixel_t sel00;
    pixel_t sel01;
    pixel_t sel10;
    pixel_t sel11;

    // Row 0 comes from the read-only ports, row 1 from the shared ones
    assign sel00 = dec.sel00 ? rdOdd0 : rdEven0;
    assign sel01 = dec.sel01 ? rdOdd0 : rdEven0;
    assign sel10 = dec.sel10 ? rdOdd1 : rdEven1;
    assign sel11 = dec.sel11 ? rdOdd1 : rdEven1;

    // Edge clamp replaces wrapped neighbours
    assign texel00 = sel00;
    assign texel01 = dec.clampS ? sel00 : sel01;
    assign texel10 = dec.clampT ? sel00 : sel10;
    assign texel11 = dec.clampS ? texel10
                   : dec.clampT ? sel01
                   : sel11;

    // An S clamp needs two or more texels per row, so the neighbour is in the other bank
    always_comb
    begin
        if (dec.clampS)
        begin
            assertClampBanks : assert (dec.sel01 != dec.sel00)
            else
            begin
                $error("texelQuadSelect: clamped S neighbour in the same bank");
            end
        end
    end

endmodule

// File: texelTop.sv
`timescale 1ns/10ps

module texelTop import texelPkg::*;
(
    input  logic              aclk,
    input  logic              resetn,

    // Configuration
    input  logic              cfgWrite,
    input  texSize_e          cfgSizeS,
    input  texSize_e          cfgSizeT,
    input  logic              cfgClampS,
    input  logic              cfgClampT,

    // Read side
    input  texCoord_t         texelS,
    input  texCoord_t         texelT,
    output pixel_t            texel00,
    output pixel_t            texel01,
    output pixel_t            texel10,
    output pixel_t            texel11,
    output subCoord_t         subCoordS,
    output subCoord_t         subCoordT,

    // Write stream
    input  logic              streamValid,
    input  logic              streamLast,
    input  streamWord_t       streamData
);

    texConfigIf  cfgBus ();
    bankWriteIf  wrBus ();
    quadDecodeIf decBus ();

    bankAddr_t rdAddrEven0;
    bankAddr_t rdAddrOdd0;
    bankAddr_t rdAddrEven1;
    bankAddr_t rdAddrOdd1;
    pixel_t    rdEven0;
    pixel_t    rdOdd0;
    pixel_t    rdEven1;
    pixel_t    rdOdd1;

    texConfigRegs configRegs (
        .aclk        (aclk),
        .resetn      (resetn),
        .cfgWrite    (cfgWrite),
        .cfgSizeS    (cfgSizeS),
        .cfgSizeT    (cfgSizeT),
        .cfgClampS   (cfgClampS),
        .cfgClampT   (cfgClampT),
        .cfg         (cfgBus.source)
    );

    texelAddrGen addrGen (
        .aclk        (aclk),
        .resetn      (resetn),
        .texelS      (texelS),
        .texelT      (texelT),
        .cfg         (cfgBus.sink),
        .rdAddrEven0 (rdAddrEven0),
        .rdAddrOdd0  (rdAddrOdd0),
        .rdAddrEven1 (rdAddrEven1),
        .rdAddrOdd1  (rdAddrOdd1),
        .dec         (decBus.source),
        .subCoordS   (subCoordS),
        .subCoordT   (subCoordT)
    );

    texelWriteCtrl writeCtrl (
        .aclk        (aclk),
        .resetn      (resetn),
        .streamValid (streamValid),
        .streamLast  (streamLast),
        .streamData  (streamData),
        .wr          (wrBus.source)
    );

    // Port A carries row 1 and the writes, port B row 0
    texelBank #(.useOdd(1'b0)) bankEven (
        .aclk        (aclk),
        .wr          (wrBus.sink),
        .rdAddrA     (rdAddrEven1),
        .rdAddrB     (rdAddrEven0),
        .rdDataA     (rdEven1),
        .rdDataB     (rdEven0)
    );

    texelBank #(.useOdd(1'b1)) bankOdd (
        .aclk        (aclk),
        .wr          (wrBus.sink),
        .rdAddrA     (rdAddrOdd1),
        .rdAddrB     (rdAddrOdd0),
        .rdDataA     (rdOdd1),
        .rdDataB     (rdOdd0)
    );

    texelQuadSelect quadSelect (
        .dec         (decBus.sink),
        .rdEven0     (rdEven0),
        .rdOdd0      (rdOdd0),
        .rdEven1     (rdEven1),
        .rdOdd1      (rdOdd1),
        .texel00     (texel00),
        .texel01     (texel01),
        .texel10     (texel10),
        .texel11     (texel11)
    );

endmodule

// File: tbTexelTop.sv
`timescale 1ns/10ps
`include "texBuffer_consts.svh"

module tbTexelTop import texelPkg::*;
();

    localparam int modelDepth = 1 << (2 * `TEX_MAX_LOG2);
    localparam int firstCount = 17;     // Reads of the 64x64 texture
    localparam int numEntries = 20;
    localparam int timeoutLimit = 2048 + 2 * 32 + numEntries + 200;

    typedef struct packed
    {
        texSize_e  sizeS;
        texSize_e  sizeT;
        logic      clampS;
        logic      clampT;
        texCoord_t s;
        texCoord_t t;
        subCoord_t expS;    // Fraction rule, worked out by hand
        subCoord_t expT;
    } readEntry_t;

    logic        aclk = 1'b0;
    logic        resetn;
    logic        cfgWrite;
    texSize_e    cfgSizeS;
    texSize_e    cfgSizeT;
    logic        cfgClampS;
    logic        cfgClampT;
    texCoord_t   texelS;
    texCoord_t   texelT;
    logic        streamValid;
    logic        streamLast;
    streamWord_t streamData;
    pixel_t      texel00;
    pixel_t      texel01;
    pixel_t      texel10;
    pixel_t      texel11;
    subCoord_t   subCoordS;
    subCoord_t   subCoordT;

    pixel_t      model [modelDepth];    // Texels in stream order
    readEntry_t  readTable [numEntries];
    int          cycleCount = 0;

    texelTop DUT (.*);

    always #4 aclk = ~aclk;

    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("Testbench failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic checkPixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic checkSubCoord(input string name, input subCoord_t got, input subCoord_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // Both texel indices of one axis and whether the neighbour wraps
    function automatic void axisIndices(input texCoord_t c, input int n,
                                        output int i0, output int i1, output bit wrap);
        texCoord_t c1;
        c1 = c + texCoord_t'(32'h8000 >> n);    // One texel further
        i0 = (n == 0) ? 0 : int'((c >> (15 - n)) & ((1 << n) - 1));
        i1 = (n == 0) ? 0 : int'((c1 >> (15 - n)) & ((1 << n) - 1));
        wrap = (c > c1) || (!c[15] && c1[15]);
    endfunction

    task automatic checkEntry(input int k);
        readEntry_t e;
        int         s0;
        int         s1;
        int         t0;
        int         t1;
        bit         wrapS;
        bit         wrapT;
        pixel_t     q00;
        pixel_t     q01;
        pixel_t     q10;
        pixel_t     q11;
        e = readTable[k];
        axisIndices(e.s, int'(e.sizeS), s0, s1, wrapS);
        axisIndices(e.t, int'(e.sizeT), t0, t1, wrapT);
        q00 = model[(t0 << int'(e.sizeS)) | s0];    // Row stride is the S size
        q01 = model[(t0 << int'(e.sizeS)) | s1];
        q10 = model[(t1 << int'(e.sizeS)) | s0];
        q11 = model[(t1 << int'(e.sizeS)) | s1];
        if (e.clampS && wrapS)
        begin
            q01 = q00;
        end
        if (e.clampT && wrapT)
        begin
            q10 = q00;
        end
        if (e.clampS && wrapS)
        begin
            q11 = q10;
        end
        else if (e.clampT && wrapT)
        begin
            q11 = q01;
        end
        checkPixel("texel00", texel00, q00);
        checkPixel("texel01", texel01, q01);
        checkPixel("texel10", texel10, q10);
        checkPixel("texel11", texel11, q11);
        checkSubCoord("subCoordS", subCoordS, e.expS);
        checkSubCoord("subCoordT", subCoordT, e.expT);
    endtask

    // Two random texels per beat, last on the final one
    task automatic streamTexture(input int beats);
        int b;
        for (b = 0; b < beats; b++)
        begin
            @(posedge aclk);
            model[2 * b]     = pixel_t'($urandom);
            model[2 * b + 1] = pixel_t'($urandom);
            streamValid <= 1'b1;
            streamLast  <= (b == beats - 1);
            streamData  <= {model[2 * b + 1], model[2 * b]};
        end
        @(posedge aclk);
        streamValid <= 1'b0;
        streamLast  <= 1'b0;
    endtask

    // Config of entry j, coordinates of j-1 and the result of j-2 in the same cycle
    task automatic applyReads(input int first, input int last);
        int j;
        for (j = first; j <= last + 2; j++)
        begin
            @(posedge aclk);
            cfgWrite <= 1'b0;
            if (j <= last && (j == first || readTable[j][71:64] != readTable[j - 1][71:64]))
            begin
                cfgWrite  <= 1'b1;  // Only when the settings change
                cfgSizeS  <= readTable[j].sizeS;
                cfgSizeT  <= readTable[j].sizeT;
                cfgClampS <= readTable[j].clampS;
                cfgClampT <= readTable[j].clampT;
            end
            if (j - 1 >= first && j - 1 <= last)
            begin
                texelS <= readTable[j - 1].s;
                texelT <= readTable[j - 1].t;
            end
            @(negedge aclk);
            if (j - 2 >= first)
            begin
                checkEntry(j - 2);
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h4bcb));
        resetn <= 1'b0;
        cfgWrite <= 1'b0;
        cfgSizeS <= SIZE_1;
        cfgSizeT <= SIZE_1;
        cfgClampS <= 1'b0;
        cfgClampT <= 1'b0;
        texelS <= '0;
        texelT <= '0;
        streamValid <= 1'b0;
        streamLast <= 1'b0;
        streamData <= '0;

        readTable[0]  = '{SIZE_64, SIZE_64, 1'b0, 1'b0, 16'h4000, 16'h4000, 16'h0000, 16'h0000};
        readTable[1]  = '{SIZE_64, SIZE_64, 1'b0, 1'b0, 16'h4123, 16'h3a57, 16'h9180, 16'h2b80};
        readTable[2]  = '{SIZE_64, SIZE_64, 1'b0, 1'b0, 16'h4200, 16'h2000, 16'h0000, 16'h0000};
        readTable[3]  = '{SIZE_64, SIZE_64, 1'b0, 1'b0, 16'h0e55, 16'h7c10, 16'h2a80, 16'h0800};
        readTable[4]  = '{SIZE_1,  SIZE_1,  1'b0, 1'b0, 16'h5a5a, 16'h2c3d, 16'h0000, 16'h0000};
        readTable[5]  = '{SIZE_2,  SIZE_2,  1'b0, 1'b0, 16'h5a5a, 16'h2c3d, 16'h6968, 16'hb0f4};
        readTable[6]  = '{SIZE_4,  SIZE_4,  1'b0, 1'b0, 16'h5a5a, 16'h2c3d, 16'hd2d0, 16'h61e8};
        readTable[7]  = '{SIZE_8,  SIZE_8,  1'b0, 1'b0, 16'h5a5a, 16'h2c3d, 16'ha5a0, 16'hc3d0};
        readTable[8]  = '{SIZE_16, SIZE_16, 1'b0, 1'b0, 16'h5a5a, 16'h2c3d, 16'h4b40, 16'h87a0};
        readTable[9]  = '{SIZE_32, SIZE_32, 1'b0, 1'b0, 16'h5a5a, 16'h2c3d, 16'h9680, 16'h0f40};
        readTable[10] = '{SIZE_64, SIZE_64, 1'b0, 1'b0, 16'h5a5a, 16'h2c3d, 16'h2d00, 16'h1e80};
        readTable[11] = '{SIZE_8,  SIZE_32, 1'b0, 1'b0, 16'h5a5a, 16'h2c3d, 16'ha5a0, 16'h0f40};
        readTable[12] = '{SIZE_64, SIZE_64, 1'b0, 1'b0, 16'h7f00, 16'h7e80, 16'h8000, 16'h4000};
        readTable[13] = '{SIZE_64, SIZE_64, 1'b1, 1'b0, 16'h7f00, 16'h7e80, 16'h8000, 16'h4000};
        readTable[14] = '{SIZE_64, SIZE_64, 1'b0, 1'b1, 16'h7f00, 16'h7e80, 16'h8000, 16'h4000};
        readTable[15] = '{SIZE_64, SIZE_64, 1'b1, 1'b1, 16'h7f00, 16'h7e80, 16'h8000, 16'h4000};
        readTable[16] = '{SIZE_64, SIZE_64, 1'b1, 1'b0, 16'hff00, 16'h1000, 16'h8000, 16'h0000};
        readTable[17] = '{SIZE_8,  SIZE_8,  1'b0, 1'b0, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
        readTable[18] = '{SIZE_8,  SIZE_8,  1'b0, 1'b0, 16'h3000, 16'h5800, 16'h0000, 16'h8000};
        readTable[19] = '{SIZE_8,  SIZE_8,  1'b1, 1'b1, 16'h7800, 16'h7000, 16'h8000, 16'h0000};

        repeat (16) @(posedge aclk);
        resetn <= 1'b1;

        streamTexture(2048);
        applyReads(0, firstCount - 1);
        streamTexture(32);      // 8x8 texture, overwrites the first 64 texels
        streamTexture(32);      // Lands at 0 only if the last at address 31 restarted it
        applyReads(firstCount, numEntries - 1);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
texelPkg.sv
texelIfs.sv
texConfigRegs.sv
texelAddrGen.sv
texelWriteCtrl.sv
texelBank.sv
texelQuadSelect.sv
texelTop.sv
tbTexelTop.sv

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tbTexelTop -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }
